// File: Bender.yml
package:
  name: entropy_ht

sources:
  - files:
      - logic/ht_pkg.sv
      - logic/ht_event_if.sv
      - logic/ht_red_counter.sv
      - logic/ht_repcnt.sv
      - logic/ht_adaptp.sv
      - logic/ht_event_arbiter.sv
      - logic/ht_event_log.sv
      - logic/entropy_ht_top.sv
  - target: test
    files:
      - test/tb_entropy_ht.sv

// File: logic/entropy_ht_top.sv
/*
 * Entropy source health-test block.
 * Runs the repetition count and adaptive proportion tests on the raw noise
 * bus and records their events in a log that software reads by address.
 */
`timescale 1ns/1ps
`default_nettype none

module entropy_ht_top import ht_pkg::*; #(
  parameter int RngBusWidth = 4,
  parameter int WinSize     = 64,
  parameter int LogDepth    = 8
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [RngBusWidth-1:0]      entropy_i,
  input  logic                        entropy_vld_i,
  input  logic                        clear_i,
  input  logic                        active_i,
  input  logic [CntWidth-1:0]         repcnt_thresh_i,
  input  logic [CntWidth-1:0]         adaptp_thresh_i,
  output logic [CntWidth-1:0]         repcnt_cnt_o,
  output logic [CntWidth-1:0]         adaptp_cnt_o,
  output logic                        repcnt_fail_o,
  output logic                        adaptp_fail_o,
  output logic                        count_err_o,
  input  logic [$clog2(LogDepth)-1:0] log_rd_addr_i,
  output logic                        log_src_o,
  output logic                        log_kind_o,
  output logic [CntWidth-1:0]         log_payload_o,
  output logic [$clog2(LogDepth):0]   log_entries_o
);

  logic                     repcnt_cnt_err;
  logic                     adaptp_cnt_err;
  logic                     log_wr_en;
  logic [LogEntryWidth-1:0] log_wr_data;

  ht_event_if repcnt_evt ();
  ht_event_if adaptp_evt ();

  ht_repcnt #(
    .RngBusWidth(RngBusWidth)
  ) u_repcnt (
    .clk_i,
    .rst_ni,
    .sample_i    (entropy_i),
    .sample_vld_i(entropy_vld_i),
    .clear_i,
    .active_i,
    .thresh_i    (repcnt_thresh_i),
    .cnt_o       (repcnt_cnt_o),
    .fail_o      (repcnt_fail_o),
    .cnt_err_o   (repcnt_cnt_err),
    .evt_o       (repcnt_evt)
  );

  ht_adaptp #(
    .RngBusWidth(RngBusWidth),
    .WinSize    (WinSize)
  ) u_adaptp (
    .clk_i,
    .rst_ni,
    .sample_i    (entropy_i),
    .sample_vld_i(entropy_vld_i),
    .clear_i,
    .active_i,
    .thresh_i    (adaptp_thresh_i),
    .cnt_o       (adaptp_cnt_o),
    .fail_o      (adaptp_fail_o),
    .cnt_err_o   (adaptp_cnt_err),
    .evt_o       (adaptp_evt)
  );

  ht_event_arbiter u_arbiter (
    .clk_i,
    .rst_ni,
    .repcnt_evt_i(repcnt_evt),
    .adaptp_evt_i(adaptp_evt),
    .wr_en_o     (log_wr_en),
    .wr_data_o   (log_wr_data)
  );

  ht_event_log #(
    .LogDepth(LogDepth)
  ) u_log (
    .clk_i,
    .rst_ni,
    .wr_en_i     (log_wr_en),
    .wr_data_i   (log_wr_data),
    .rd_addr_i   (log_rd_addr_i),
    .rd_src_o    (log_src_o),
    .rd_kind_o   (log_kind_o),
    .rd_payload_o(log_payload_o),
    .entries_o   (log_entries_o)
  );

  assign count_err_o = repcnt_cnt_err || adaptp_cnt_err;

endmodule

`default_nettype wire

// File: logic/ht_adaptp.sv
/*
 * Adaptive proportion test over every lane of the noise bus.
 * Ones are counted per lane across a window of WinSize valid samples.
 * At the window end the larger of ones and zeros, over all lanes, is
 * registered and checked against the threshold in the next cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module ht_adaptp import ht_pkg::*; #(
  parameter int RngBusWidth = 4,
  parameter int WinSize     = 64
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [RngBusWidth-1:0] sample_i,
  input  logic                   sample_vld_i,
  input  logic                   clear_i,
  input  logic                   active_i,
  input  logic [CntWidth-1:0]    thresh_i,
  output logic [CntWidth-1:0]    cnt_o,
  output logic                   fail_o,
  output logic                   cnt_err_o,
  ht_event_if.requester          evt_o
);

  localparam int WinWidth = $clog2(WinSize + 1);

  logic [WinWidth-1:0]                  win_cnt_q, win_cnt_d;
  logic                                 win_end;
  logic                                 restart;
  logic [RngBusWidth-1:0][CntWidth-1:0] ones_cnt;
  logic [RngBusWidth-1:0][CntWidth-1:0] ones_final;
  logic [RngBusWidth-1:0][CntWidth-1:0] zeros_final;
  logic [RngBusWidth-1:0][CntWidth-1:0] lane_max;
  logic [RngBusWidth-1:0]               ones_cnt_err;
  logic [CntWidth-1:0]                  win_max;
  logic [CntWidth-1:0]                  max_q;
  logic                                 fail_mask_q;

  logic        new_evt;
  ht_kind_e    new_kind;
  ht_payload_u new_payload;
  logic        pend_q;
  ht_kind_e    pend_kind_q;
  ht_payload_u pend_payload_q;

  assign restart = !active_i || clear_i;
  assign win_end = !restart && sample_vld_i && (win_cnt_q == WinWidth'(WinSize - 1));

  always_comb begin
    win_cnt_d = win_cnt_q;
    if (restart || win_end) begin
      win_cnt_d = '0;
    end else if (sample_vld_i) begin
      win_cnt_d = win_cnt_q + WinWidth'(1);
    end
  end

  for (genvar ln = 0; ln < RngBusWidth; ln++) begin : gen_lane
    ht_red_counter u_ones_cnt (
      .clk_i,
      .rst_ni,
      .set_i    (restart || win_end),
      .set_val_i('0),
      .incr_i   (sample_vld_i && sample_i[ln]),
      .cnt_o    (ones_cnt[ln]),
      .err_o    (ones_cnt_err[ln])
    );

    // Include the last sample of the window
    assign ones_final[ln]  = ones_cnt[ln] + CntWidth'(sample_i[ln]);
    assign zeros_final[ln] = CntWidth'(WinSize) - ones_final[ln];
    assign lane_max[ln]    = (ones_final[ln] >= zeros_final[ln]) ? ones_final[ln] :
                                                                   zeros_final[ln];
  end

  always_comb begin
    win_max = '0;
    for (int i = 0; i < RngBusWidth; i++) begin
      if (lane_max[i] > win_max) begin
        win_max = lane_max[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      win_cnt_q   <= '0;
      max_q       <= '0;
      fail_mask_q <= 1'b0;
    end else begin
      win_cnt_q   <= win_cnt_d;
      fail_mask_q <= win_end;
      if (win_end) begin
        max_q <= win_max;
      end
    end
  end

  assign fail_o    = fail_mask_q && (max_q >= thresh_i);
  assign cnt_o     = max_q;
  assign cnt_err_o = |ones_cnt_err;

  always_comb begin
    new_payload = '0;
    if (fail_o) begin
      new_kind            = KindFail;
      new_payload.max_cnt = max_q;
    end else begin
      new_kind                  = KindCntErr;
      new_payload.err.lane_mask = ErrMaskWidth'(ones_cnt_err);
    end
  end

  assign new_evt = fail_o || cnt_err_o;

  // Hold one event until granted, drop any that arrive meanwhile
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else if (pend_q) begin
      pend_q <= evt_o.gnt ? new_evt : 1'b1;
    end else begin
      pend_q <= new_evt && !evt_o.gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (new_evt && (pend_q == evt_o.gnt)) begin
      pend_kind_q    <= new_kind;
      pend_payload_q <= new_payload;
    end
  end

  assign evt_o.req     = pend_q || new_evt;
  assign evt_o.src     = SrcAdaptp;
  assign evt_o.kind    = pend_q ? pend_kind_q : new_kind;
  assign evt_o.payload = pend_q ? pend_payload_q : new_payload;

endmodule

`default_nettype wire

// File: logic/ht_event_arbiter.sv
/*
 * Round-robin arbiter between the two health test event ports.
 * Grants are combinational; the granted event is packed into a log word
 * and written at the same clock edge.
 */
`timescale 1ns/1ps
`default_nettype none

module ht_event_arbiter import ht_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  ht_event_if.arbiter              repcnt_evt_i,
  ht_event_if.arbiter              adaptp_evt_i,
  output logic                     wr_en_o,
  output logic [LogEntryWidth-1:0] wr_data_o
);

  ht_src_e last_gnt_q;
  logic    gnt_repcnt;
  logic    gnt_adaptp;

  // On a tie the port not granted last time wins
  assign gnt_repcnt = repcnt_evt_i.req &&
                      (!adaptp_evt_i.req || (last_gnt_q == SrcAdaptp));
  assign gnt_adaptp = adaptp_evt_i.req &&
                      (!repcnt_evt_i.req || (last_gnt_q == SrcRepcnt));

  assign repcnt_evt_i.gnt = gnt_repcnt;
  assign adaptp_evt_i.gnt = gnt_adaptp;

  // Starting as if adaptp went last gives repcnt priority out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_gnt_q <= SrcAdaptp;
    end else if (gnt_repcnt) begin
      last_gnt_q <= SrcRepcnt;
    end else if (gnt_adaptp) begin
      last_gnt_q <= SrcAdaptp;
    end
  end

  assign wr_en_o = gnt_repcnt || gnt_adaptp;

  always_comb begin
    if (gnt_adaptp) begin
      wr_data_o = {adaptp_evt_i.src, adaptp_evt_i.kind, adaptp_evt_i.payload};
    end else begin
      wr_data_o = {repcnt_evt_i.src, repcnt_evt_i.kind, repcnt_evt_i.payload};
    end
  end

endmodule

`default_nettype wire

// File: logic/ht_event_if.sv
/*
 * One event request from a health test to the log arbiter.
 * The test holds req with its event fields until gnt comes back.
 */
`timescale 1ns/1ps
`default_nettype none

interface ht_event_if import ht_pkg::*; ();

  logic        req;
  logic        gnt;
  ht_src_e     src;
  ht_kind_e    kind;
  ht_payload_u payload;

  // Health test side
  modport requester (
    output req, src, kind, payload,
    input  gnt
  );

  // Log arbiter side
  modport arbiter (
    input  req, src, kind, payload,
    output gnt
  );

endinterface

`default_nettype wire

// File: logic/ht_event_log.sv
/*
 * Circular log of health test events.
 * New entries overwrite the oldest once the memory has wrapped. The entry
 * count saturates at LogDepth and any address can be read at any time.
 */
`timescale 1ns/1ps
`default_nettype none

module ht_event_log import ht_pkg::*; #(
  parameter int LogDepth = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       wr_en_i,
  input  logic [LogEntryWidth-1:0]   wr_data_i,
  input  logic [$clog2(LogDepth)-1:0] rd_addr_i,
  output ht_src_e                    rd_src_o,
  output ht_kind_e                   rd_kind_o,
  output ht_payload_u                rd_payload_o,
  output logic [$clog2(LogDepth):0]  entries_o
);

  localparam int AddrWidth = $clog2(LogDepth);
  localparam logic [AddrWidth:0] FullCnt = (AddrWidth + 1)'(LogDepth);

  logic [LogEntryWidth-1:0] mem_q [LogDepth];
  logic [AddrWidth-1:0]     wr_ptr_q;
  logic [AddrWidth:0]       entries_q;
  logic [LogEntryWidth-1:0] rd_word;

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  // Pointer wraps naturally since the depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      entries_q <= '0;
    end else if (wr_en_i) begin
      wr_ptr_q <= wr_ptr_q + AddrWidth'(1);
      if (entries_q != FullCnt) begin
        entries_q <= entries_q + (AddrWidth + 1)'(1);
      end
    end
  end

  assign entries_o = entries_q;

  // Unpack source, kind and payload of the addressed word
  assign rd_word      = mem_q[rd_addr_i];
  assign rd_src_o     = ht_src_e'(rd_word[LogEntryWidth-1]);
  assign rd_kind_o    = ht_kind_e'(rd_word[LogEntryWidth-2]);
  assign rd_payload_o = rd_word[CntWidth-1:0];

endmodule

`default_nettype wire

// File: logic/ht_pkg.sv
/*
 * Shared definitions for the entropy health-test block.
 * Holds the count widths, the event source and kind encodings and the
 * payload union that the log stores. Imported by every RTL file that
 * needs one of these.
 */
`default_nettype none

package ht_pkg;

  // Width of all run, ones and threshold counts
  localparam int CntWidth = 16;

  // Lane mask bits in a counter error payload
  localparam int ErrMaskWidth = 8;

  // One log word is source, kind and payload
  localparam int LogEntryWidth = 2 + CntWidth;

  typedef enum logic {
    KindFail   = 1'b0,
    KindCntErr = 1'b1
  } ht_kind_e;

  typedef enum logic {
    SrcRepcnt = 1'b0,
    SrcAdaptp = 1'b1
  } ht_src_e;

  // Payload is read as a count or as a lane mask, depending on the kind
  typedef union packed {
    logic [CntWidth-1:0] max_cnt;
    struct packed {
      logic [CntWidth-ErrMaskWidth-1:0] rsvd;
      logic [ErrMaskWidth-1:0]          lane_mask;
    } err;
  } ht_payload_u;

endpackage

`default_nettype wire

// File: logic/ht_red_counter.sv
/*
 * Saturating up counter with a load value, held twice.
 * The shadow copy stores the inverted count and counts down, so any
 * upset in either copy shows up as a mismatch on err_o.
 */
`timescale 1ns/1ps
`default_nettype none

module ht_red_counter import ht_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                set_i,
  input  logic [CntWidth-1:0] set_val_i,
  input  logic                incr_i,
  output logic [CntWidth-1:0] cnt_o,
  output logic                err_o
);

  logic [CntWidth-1:0] cnt_q, cnt_d;
  logic [CntWidth-1:0] cnt_n_q, cnt_n_d;

  // Primary count saturating at all ones
  always_comb begin
    cnt_d = cnt_q;
    if (set_i) begin
      cnt_d = set_val_i;
    end else if (incr_i && (cnt_q != '1)) begin
      cnt_d = cnt_q + CntWidth'(1);
    end
  end

  // Inverted shadow saturating at zero
  always_comb begin
    cnt_n_d = cnt_n_q;
    if (set_i) begin
      cnt_n_d = ~set_val_i;
    end else if (incr_i && (cnt_n_q != '0)) begin
      cnt_n_d = cnt_n_q - CntWidth'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      cnt_n_q <= '1;
    end else begin
      cnt_q   <= cnt_d;
      cnt_n_q <= cnt_n_d;
    end
  end

  assign cnt_o = cnt_q;
  assign err_o = (cnt_q != ~cnt_n_q);

endmodule

`default_nettype wire

// File: logic/ht_repcnt.sv
/*
 * Repetition count test over every lane of the noise bus.
 * Each lane counts how long it has held its last value; the largest run
 * is compared with the threshold once per valid sample. Failures and
 * counter errors are offered to the event log through evt_o.
 */
`timescale 1ns/1ps
`default_nettype none

module ht_repcnt import ht_pkg::*; #(
  parameter int RngBusWidth = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [RngBusWidth-1:0] sample_i,
  input  logic                   sample_vld_i,
  input  logic                   clear_i,
  input  logic                   active_i,
  input  logic [CntWidth-1:0]    thresh_i,
  output logic [CntWidth-1:0]    cnt_o,
  output logic                   fail_o,
  output logic                   cnt_err_o,
  ht_event_if.requester          evt_o
);

  logic [RngBusWidth-1:0]               prev_sample_q, prev_sample_d;
  logic [RngBusWidth-1:0]               lane_match;
  logic [RngBusWidth-1:0]               lane_no_match;
  logic [RngBusWidth-1:0][CntWidth-1:0] run_cnt;
  logic [RngBusWidth-1:0]               run_cnt_err;
  logic [CntWidth-1:0]                  cnt_max;
  logic                                 fail_mask_q;
  logic                                 restart;

  logic        new_evt;
  ht_kind_e    new_kind;
  ht_payload_u new_payload;
  logic        pend_q;
  ht_kind_e    pend_kind_q;
  ht_payload_u pend_payload_q;

  assign restart = !active_i || clear_i;

  for (genvar ln = 0; ln < RngBusWidth; ln++) begin : gen_lane
    assign prev_sample_d[ln] = restart      ? 1'b0 :
                               sample_vld_i ? sample_i[ln] :
                               prev_sample_q[ln];

    assign lane_match[ln]    = sample_vld_i && (sample_i[ln] == prev_sample_q[ln]);
    assign lane_no_match[ln] = sample_vld_i && (sample_i[ln] != prev_sample_q[ln]);

    // Run length starts at one, as in the NIST definition
    ht_red_counter u_run_cnt (
      .clk_i,
      .rst_ni,
      .set_i    (restart || lane_no_match[ln]),
      .set_val_i(CntWidth'(1)),
      .incr_i   (lane_match[ln]),
      .cnt_o    (run_cnt[ln]),
      .err_o    (run_cnt_err[ln])
    );
  end

  // Longest run over all lanes
  always_comb begin
    cnt_max = '0;
    for (int i = 0; i < RngBusWidth; i++) begin
      if (run_cnt[i] > cnt_max) begin
        cnt_max = run_cnt[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_sample_q <= '0;
      fail_mask_q   <= 1'b0;
    end else begin
      prev_sample_q <= prev_sample_d;
      fail_mask_q   <= sample_vld_i;
    end
  end

  // Look at the counters only in the cycle right after they moved
  assign fail_o    = active_i && fail_mask_q && (cnt_max >= thresh_i);
  assign cnt_o     = cnt_max;
  assign cnt_err_o = |run_cnt_err;

  // A failure wins over a counter error in the same cycle
  always_comb begin
    new_payload = '0;
    if (fail_o) begin
      new_kind            = KindFail;
      new_payload.max_cnt = cnt_max;
    end else begin
      new_kind                  = KindCntErr;
      new_payload.err.lane_mask = ErrMaskWidth'(run_cnt_err);
    end
  end

  assign new_evt = fail_o || cnt_err_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else if (pend_q) begin
      pend_q <= evt_o.gnt ? new_evt : 1'b1;
    end else begin
      pend_q <= new_evt && !evt_o.gnt;
    end
  end

  // New events are taken only when nothing is left waiting
  always_ff @(posedge clk_i) begin
    if (new_evt && (pend_q == evt_o.gnt)) begin
      pend_kind_q    <= new_kind;
      pend_payload_q <= new_payload;
    end
  end

  assign evt_o.req     = pend_q || new_evt;
  assign evt_o.src     = SrcRepcnt;
  assign evt_o.kind    = pend_q ? pend_kind_q : new_kind;
  assign evt_o.payload = pend_q ? pend_payload_q : new_payload;

endmodule

`default_nettype wire

// File: test/tb_entropy_ht.sv
/*
 * Random-stimulus testbench for the entropy health-test block.
 * A cycle-level model of both tests, the event arbiter and the log runs
 * next to the DUT, and every output is compared with it once per cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_entropy_ht import ht_pkg::*; ();

  localparam int RngBusWidth = 4;
  localparam int WinSize     = 16;
  localparam int LogDepth    = 8;
  localparam int AddrWidth   = $clog2(LogDepth);
  localparam int NumCycles   = 3000;
  localparam int CycleLimit  = NumCycles + 200;
  localparam int RepThresh   = 7;
  localparam int ApThresh    = 13;

  logic                   clk_i;
  logic                   rst_ni;
  logic [RngBusWidth-1:0] entropy_i;
  logic                   entropy_vld_i;
  logic                   clear_i;
  logic                   active_i;
  logic [CntWidth-1:0]    repcnt_thresh_i;
  logic [CntWidth-1:0]    adaptp_thresh_i;
  logic [CntWidth-1:0]    repcnt_cnt_o;
  logic [CntWidth-1:0]    adaptp_cnt_o;
  logic                   repcnt_fail_o;
  logic                   adaptp_fail_o;
  logic                   count_err_o;
  logic [AddrWidth-1:0]   log_rd_addr_i;
  logic                   log_src_o;
  logic                   log_kind_o;
  logic [CntWidth-1:0]    log_payload_o;
  logic [AddrWidth:0]     log_entries_o;

  integer seed = 32'h53b9_82ea;
  int     error_cnt;
  int     check_cnt;
  int     write_cnt;
  int     contend_cnt;
  int     cycle_cnt;

  // Stimulus phase state
  int                     phase_mode;
  int                     phase_left;
  logic [RngBusWidth-1:0] stuck_bits;

  // Reference model state as held after the last clock edge
  logic [RngBusWidth-1:0] prev_bits;
  int                     run_len [RngBusWidth];
  logic                   rep_mask;
  int                     win_pos;
  int                     ones_cnt [RngBusWidth];
  int                     ap_max;
  logic                   ap_mask;
  logic                   pend [2];
  int                     pend_val [2];
  int                     last_src;
  logic                   exp_log_vld [LogDepth];
  logic                   exp_log_src [LogDepth];
  int                     exp_log_val [LogDepth];
  int                     wr_ptr;
  int                     entries;

  entropy_ht_top #(
    .RngBusWidth(RngBusWidth),
    .WinSize    (WinSize),
    .LogDepth   (LogDepth)
  ) i_dut (
    .clk_i,
    .rst_ni,
    .entropy_i,
    .entropy_vld_i,
    .clear_i,
    .active_i,
    .repcnt_thresh_i,
    .adaptp_thresh_i,
    .repcnt_cnt_o,
    .adaptp_cnt_o,
    .repcnt_fail_o,
    .adaptp_fail_o,
    .count_err_o,
    .log_rd_addr_i,
    .log_src_o,
    .log_kind_o,
    .log_payload_o,
    .log_entries_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      error_cnt++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic reset_model();
    prev_bits = '0;
    rep_mask  = 1'b0;
    win_pos   = 0;
    ap_max    = 0;
    ap_mask   = 1'b0;
    last_src  = 1;
    wr_ptr    = 0;
    entries   = 0;
    for (int i = 0; i < RngBusWidth; i++) begin
      run_len[i]  = 0;
      ones_cnt[i] = 0;
    end
    for (int k = 0; k < 2; k++) begin
      pend[k]     = 1'b0;
      pend_val[k] = 0;
    end
    for (int a = 0; a < LogDepth; a++) begin
      exp_log_vld[a] = 1'b0;
    end
  endtask

  // Stuck lanes, plain random bits or mostly ones in phases of random length
  task automatic drive_random();
    int r;
    int flip;
    if (phase_left == 0) begin
      phase_mode = $unsigned($random(seed)) % 3;
      phase_left = 40 + $unsigned($random(seed)) % 120;
      stuck_bits = RngBusWidth'($random(seed));
    end
    phase_left--;
    r = $random(seed);
    case (phase_mode)
      0: begin
        entropy_i = stuck_bits;
        if (($unsigned(r) % 16) == 0) begin
          flip = $unsigned(r >> 8) % RngBusWidth;
          entropy_i[flip] = !entropy_i[flip];
        end
      end
      1: entropy_i = RngBusWidth'(r);
      default: begin
        for (int i = 0; i < RngBusWidth; i++) begin
          entropy_i[i] = ($unsigned($random(seed)) % 8) != 0;
        end
      end
    endcase
    entropy_vld_i = ($unsigned($random(seed)) % 5) != 0;
    clear_i       = ($unsigned($random(seed)) % 97) == 0;
    if (active_i && (($unsigned($random(seed)) % 150) == 0)) begin
      active_i = 1'b0;
    end else if (!active_i && (($unsigned($random(seed)) % 6) == 0)) begin
      active_i = 1'b1;
    end
    log_rd_addr_i = AddrWidth'($random(seed));
  endtask

  // Compare outputs for the current inputs, then apply the coming clock edge
  task automatic check_and_advance();
    logic restart;
    logic win_end;
    logic rep_fail;
    logic ap_fail;
    logic req [2];
    logic gnt [2];
    logic new_evt [2];
    int   new_val [2];
    int   payload [2];
    int   rep_max;
    int   win_max;
    int   lane_ones;
    int   lane_zeros;
    int   s;
    restart = !active_i || clear_i;
    rep_max = 0;
    for (int i = 0; i < RngBusWidth; i++) begin
      if (run_len[i] > rep_max) begin
        rep_max = run_len[i];
      end
    end
    rep_fail = active_i && rep_mask && (rep_max >= RepThresh);
    ap_fail  = ap_mask && (ap_max >= ApThresh);

    check_value("repcnt_cnt_o", repcnt_cnt_o, rep_max);
    check_value("repcnt_fail_o", repcnt_fail_o, rep_fail);
    check_value("adaptp_cnt_o", adaptp_cnt_o, ap_max);
    check_value("adaptp_fail_o", adaptp_fail_o, ap_fail);
    check_value("count_err_o", count_err_o, 1'b0);
    check_value("log_entries_o", log_entries_o, entries);
    if (exp_log_vld[log_rd_addr_i]) begin
      check_value("log_src_o", log_src_o, exp_log_src[log_rd_addr_i]);
      check_value("log_kind_o", log_kind_o, KindFail);
      check_value("log_payload_o", log_payload_o, exp_log_val[log_rd_addr_i]);
    end

    // Requests and round-robin grant with index 0 for repcnt
    new_evt[0] = rep_fail;
    new_evt[1] = ap_fail;
    new_val[0] = rep_max;
    new_val[1] = ap_max;
    for (int k = 0; k < 2; k++) begin
      req[k]     = pend[k] || new_evt[k];
      payload[k] = pend[k] ? pend_val[k] : new_val[k];
    end
    gnt[0] = req[0] && (!req[1] || (last_src == 1));
    gnt[1] = req[1] && (!req[0] || (last_src == 0));
    if (req[0] && req[1]) begin
      contend_cnt++;
    end
    if (gnt[0] || gnt[1]) begin
      s = gnt[1] ? 1 : 0;
      exp_log_vld[wr_ptr] = 1'b1;
      exp_log_src[wr_ptr] = s[0];
      exp_log_val[wr_ptr] = payload[s];
      wr_ptr   = (wr_ptr + 1) % LogDepth;
      entries  = (entries < LogDepth) ? entries + 1 : entries;
      last_src = s;
      write_cnt++;
    end
    // A waiting event is kept until granted and later ones are dropped
    for (int k = 0; k < 2; k++) begin
      if (!(pend[k] && !gnt[k])) begin
        pend[k]     = pend[k] ? new_evt[k] : (new_evt[k] && !gnt[k]);
        pend_val[k] = new_val[k];
      end
    end

    for (int i = 0; i < RngBusWidth; i++) begin
      if (restart) begin
        run_len[i] = 1;
      end else if (entropy_vld_i) begin
        if (entropy_i[i] == prev_bits[i]) begin
          run_len[i] = (run_len[i] < 65535) ? run_len[i] + 1 : run_len[i];
        end else begin
          run_len[i] = 1;
        end
      end
    end
    prev_bits = restart ? '0 : (entropy_vld_i ? entropy_i : prev_bits);
    rep_mask  = entropy_vld_i;

    // Window end includes the sample taken at this edge
    win_end = !restart && entropy_vld_i && (win_pos == WinSize - 1);
    if (win_end) begin
      win_max = 0;
      for (int i = 0; i < RngBusWidth; i++) begin
        lane_ones  = ones_cnt[i] + entropy_i[i];
        lane_zeros = WinSize - lane_ones;
        if (lane_ones > win_max) begin
          win_max = lane_ones;
        end
        if (lane_zeros > win_max) begin
          win_max = lane_zeros;
        end
      end
      ap_max = win_max;
    end
    ap_mask = win_end;
    for (int i = 0; i < RngBusWidth; i++) begin
      if (restart || win_end) begin
        ones_cnt[i] = 0;
      end else if (entropy_vld_i && entropy_i[i]) begin
        ones_cnt[i]++;
      end
    end
    win_pos = (restart || win_end) ? 0 : (entropy_vld_i ? win_pos + 1 : win_pos);
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CycleLimit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Run did not finish within %0d cycles, stopped by the watchdog", CycleLimit);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst_ni          = 1'b0;
    entropy_i       = '0;
    entropy_vld_i   = 1'b0;
    clear_i         = 1'b0;
    active_i        = 1'b1;
    repcnt_thresh_i = CntWidth'(RepThresh);
    adaptp_thresh_i = CntWidth'(ApThresh);
    log_rd_addr_i   = '0;
    error_cnt       = 0;
    check_cnt       = 0;
    write_cnt       = 0;
    contend_cnt     = 0;
    phase_left      = 0;
    phase_mode      = 0;
    stuck_bits      = '0;
    reset_model();

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int c = 0; c < NumCycles; c++) begin
      drive_random();
      #10;
      check_and_advance();
      @(negedge clk_i);
    end

    // Idle sweep over every log address
    for (int a = 0; a < LogDepth; a++) begin
      entropy_vld_i = 1'b0;
      clear_i       = 1'b0;
      active_i      = 1'b1;
      log_rd_addr_i = AddrWidth'(a);
      #10;
      check_and_advance();
      @(negedge clk_i);
    end

    $display("Summary: %0d checks, %0d log writes, %0d contended cycles, %0d errors",
             check_cnt, write_cnt, contend_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
logic/ht_pkg.sv
logic/ht_event_if.sv
logic/ht_red_counter.sv
logic/ht_repcnt.sv
logic/ht_adaptp.sv
logic/ht_event_arbiter.sv
logic/ht_event_log.sv
logic/entropy_ht_top.sv
test/tb_entropy_ht.sv
